// File: verilog/morsePkg.sv
/* shared constants, Morse code types, FSM enums, player status struct
   and the character code to Morse lookup */
`default_nettype none

package morsePkg;

	localparam int numLetters = 5;
	localparam int symbolSlots = 5;
	localparam int dashThreshold = 5;
	localparam int maxLetterCode = 36;
	localparam int holdBits = $clog2(dashThreshold + 1);

	typedef logic [2*symbolSlots-1:0] morseCodeT; // msb slot is the first symbol
	typedef logic [5:0] letterCodeT;
	typedef morseCodeT [numLetters-1:0] puzzleT;

	typedef enum logic [1:0] {
		symNone = 2'b00,
		symDot  = 2'b10,
		symDash = 2'b11
	} symbolT;

	typedef enum logic [2:0] {
		gsStart,
		gsStartWait,
		gsGenerate,
		gsPlay,
		gsWin1,
		gsWin2,
		gsFinishWait
	} gameStateT;

	typedef enum logic [1:0] {
		psInput,
		psVerifyWait,
		psVerify
	} playerStateT;

	typedef struct packed {
		morseCodeT entered;
		morseCodeT target;
		logic [2:0] lettersDone;
		logic correct;
	} playerStatusT;

	function automatic morseCodeT letterToMorse(input letterCodeT letter);
		morseCodeT m;
		case (letter)
			6'd1:  m = 10'b11_11_11_11_11; // 0
			6'd2:  m = 10'b10_11_11_11_11;
			6'd3:  m = 10'b10_10_11_11_11;
			6'd4:  m = 10'b10_10_10_11_11;
			6'd5:  m = 10'b10_10_10_10_11;
			6'd6:  m = 10'b10_10_10_10_10; // 5
			6'd7:  m = 10'b11_10_10_10_10;
			6'd8:  m = 10'b11_11_10_10_10;
			6'd9:  m = 10'b11_11_11_10_10;
			6'd10: m = 10'b11_11_11_11_10; // 9
			6'd11: m = 10'b10_11_00_00_00; // a
			6'd12: m = 10'b11_10_10_10_00;
			6'd13: m = 10'b11_10_11_10_00;
			6'd14: m = 10'b11_10_10_00_00;
			6'd15: m = 10'b10_00_00_00_00;
			6'd16: m = 10'b10_10_11_10_00;
			6'd17: m = 10'b11_11_10_00_00;
			6'd18: m = 10'b10_10_10_10_00;
			6'd19: m = 10'b10_10_00_00_00;
			6'd20: m = 10'b10_11_11_11_00;
			6'd21: m = 10'b11_10_11_00_00;
			6'd22: m = 10'b10_11_10_10_00;
			6'd23: m = 10'b11_11_00_00_00; // m
			6'd24: m = 10'b11_10_00_00_00;
			6'd25: m = 10'b11_11_11_00_00;
			6'd26: m = 10'b10_11_11_10_00;
			6'd27: m = 10'b11_11_10_11_00;
			6'd28: m = 10'b10_11_10_00_00;
			6'd29: m = 10'b10_10_10_00_00;
			6'd30: m = 10'b11_00_00_00_00;
			6'd31: m = 10'b10_10_11_00_00;
			6'd32: m = 10'b10_10_10_11_00;
			6'd33: m = 10'b10_11_11_00_00;
			6'd34: m = 10'b11_10_10_11_00;
			6'd35: m = 10'b11_10_11_11_00;
			6'd36: m = 10'b11_11_10_10_00; // z
			default: m = '0; // not a character
		endcase
		return m;
	endfunction

endpackage

`default_nettype wire

// File: verilog/morseKeyer.sv
/* single button Morse keyer, press timing into dot or dash
   and assembly of the entered code */
`timescale 1ns/1ps
`default_nettype none

module morseKeyer import morsePkg::*; (
	input logic clk,
	input logic reset,
	input logic keyIn, // active low
	input logic enable,
	input logic clear,
	output morseCodeT code
);

	typedef enum logic {
		kIdle,
		kHeld
	} keyStateT;

	keyStateT state;
	logic [holdBits-1:0] holdCount;
	logic [2:0] slotsUsed;
	logic [3:0] slotMsb;
	symbolT symbol;

	always_comb begin
		symbol = symNone;
		if (state == kHeld && keyIn) begin // release seen this cycle
			symbol = (holdCount >= holdBits'(dashThreshold)) ? symDash : symDot;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= kIdle;
			holdCount <= '0;
		end else begin
			case (state)
				kIdle: begin
					if (!keyIn) begin
						state <= kHeld;
						holdCount <= holdBits'(1);
					end
				end
				kHeld: begin
					if (keyIn) begin
						state <= kIdle;
					end else if (holdCount < holdBits'(dashThreshold)) begin
						holdCount <= holdCount + 1'b1; // saturates at threshold
					end
				end
				default: state <= kIdle;
			endcase
		end
	end

	assign slotMsb = 4'(2*symbolSlots - 1) - {slotsUsed, 1'b0};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			code <= '0;
			slotsUsed <= '0;
		end else if (clear) begin
			code <= '0;
			slotsUsed <= '0;
		end else if (enable && symbol != symNone) begin
			if (slotsUsed < 3'(symbolSlots)) begin
				code[slotMsb -: 2] <= symbol;
				slotsUsed <= slotsUsed + 1'b1;
			end else begin
				code <= {code[2*symbolSlots-3:0], symbol}; // full, drop oldest symbol
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/letterGenerator.sv
/* LFSR based puzzle generator, filters codes 1..36 into five Morse targets */
`timescale 1ns/1ps
`default_nettype none

module letterGenerator import morsePkg::*; (
	input logic clk,
	input logic reset,
	input logic [5:0] seed,
	input logic generateLetters,
	output puzzleT puzzle,
	output logic generated
);

	letterCodeT lfsr;
	logic [2:0] acceptCount;
	logic genPrev;
	logic valid;

	assign valid = (lfsr >= 6'd1) && (lfsr <= 6'(maxLetterCode));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			lfsr <= 6'd1;
			acceptCount <= '0;
			genPrev <= 1'b0;
			generated <= 1'b0;
			puzzle <= '0;
		end else begin
			genPrev <= generateLetters;
			if (!generateLetters) begin
				generated <= 1'b0;
			end else if (!genPrev) begin
				// first cycle of a new generation run
				lfsr <= (seed == 6'd0) ? 6'd1 : seed;
				acceptCount <= '0;
				generated <= 1'b0;
			end else if (!generated) begin
				lfsr <= {lfsr[0] ^ lfsr[1], lfsr[5:1]};
				if (valid) begin
					puzzle[acceptCount] <= letterToMorse(lfsr);
					acceptCount <= acceptCount + 1'b1;
					if (acceptCount == 3'(numLetters - 1)) begin
						generated <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/gameControl.sv
/* game level FSM, start handshake, puzzle generation, play and win states */
`timescale 1ns/1ps
`default_nettype none

module gameControl import morsePkg::*; (
	input logic clk,
	input logic reset,
	input logic [1:0] proceed, // active low buttons
	input logic generated,
	input logic [1:0] allDone,
	output logic generateLetters,
	output logic play,
	output logic win1,
	output logic win2
);

	gameStateT state;
	gameStateT nextState;
	logic anyPressed;
	logic allReleased;

	assign anyPressed = ~&proceed;
	assign allReleased = &proceed;

	always_comb begin
		nextState = state;
		case (state)
			gsStart: begin
				if (anyPressed) nextState = gsStartWait;
			end
			gsStartWait: begin
				if (allReleased) nextState = gsGenerate;
			end
			gsGenerate: begin
				if (generated) nextState = gsPlay;
			end
			gsPlay: begin
				if (allDone[0]) begin
					nextState = gsWin1; // player 1 takes a tie
				end else if (allDone[1]) begin
					nextState = gsWin2;
				end
			end
			gsWin1, gsWin2: begin
				if (anyPressed) nextState = gsFinishWait;
			end
			gsFinishWait: begin
				if (allReleased) nextState = gsStart;
			end
			default: nextState = gsStart;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= gsStart;
		end else begin
			state <= nextState;
		end
	end

	assign generateLetters = (state == gsGenerate);
	assign play = (state == gsPlay);
	assign win1 = (state == gsWin1);
	assign win2 = (state == gsWin2);

endmodule

`default_nettype wire

// File: verilog/playerMatch.sv
/* per player verify FSM, target selection and letter progress */
`timescale 1ns/1ps
`default_nettype none

module playerMatch import morsePkg::*; (
	input logic clk,
	input logic reset,
	input logic proceed, // active low
	input logic play,
	input puzzleT puzzle,
	input morseCodeT entered,
	output logic keyEnable,
	output logic keyClear,
	output playerStatusT status,
	output logic allDone
);

	playerStateT state;
	logic [2:0] lettersDone;
	morseCodeT target;
	logic match;

	assign allDone = (lettersDone == 3'(numLetters));
	assign target = allDone ? '0 : puzzle[lettersDone];

	// empty entry never counts as a match
	assign match = play && (entered != '0) && (entered == target);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= psInput;
			lettersDone <= '0;
		end else if (!play) begin
			state <= psInput;
			lettersDone <= '0;
		end else begin
			case (state)
				psInput: begin
					if (!proceed) state <= psVerifyWait;
				end
				psVerifyWait: begin
					if (proceed) state <= psVerify;
				end
				psVerify: begin
					state <= psInput;
					if (match) lettersDone <= lettersDone + 1'b1;
				end
				default: state <= psInput;
			endcase
		end
	end

	assign keyEnable = play && (state == psInput) && !allDone;
	assign keyClear = !play || (state == psVerify); // entry wiped after each check

	assign status = '{entered, target, lettersDone, match};

endmodule

`default_nettype wire

// File: verilog/statusDisplay.sv
/* seven segment and LED drive for entered codes, match and win flags */
`timescale 1ns/1ps
`default_nettype none

module statusDisplay import morsePkg::*; (
	input playerStatusT status1,
	input playerStatusT status2,
	input logic win1,
	input logic win2,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [9:0] ledr
);

	// segments gfedcba, a low bit lights the segment
	function automatic logic [6:0] hexSeg(input logic [3:0] digit);
		logic [6:0] seg;
		case (digit)
			4'h0: seg = 7'b100_0000;
			4'h1: seg = 7'b111_1001;
			4'h2: seg = 7'b010_0100;
			4'h3: seg = 7'b011_0000;
			4'h4: seg = 7'b001_1001;
			4'h5: seg = 7'b001_0010;
			4'h6: seg = 7'b000_0010;
			4'h7: seg = 7'b111_1000;
			4'h8: seg = 7'b000_0000;
			4'h9: seg = 7'b001_1000;
			4'ha: seg = 7'b000_1000;
			4'hb: seg = 7'b000_0011;
			4'hc: seg = 7'b100_0110;
			4'hd: seg = 7'b010_0001;
			4'he: seg = 7'b000_0110;
			default: seg = 7'b000_1110; // f
		endcase
		return seg;
	endfunction

	assign hex0 = hexSeg(status1.entered[3:0]);
	assign hex1 = hexSeg(status1.entered[7:4]);
	assign hex2 = hexSeg({2'b00, status1.entered[9:8]});
	assign hex3 = hexSeg(status2.entered[3:0]);
	assign hex4 = hexSeg(status2.entered[7:4]);
	assign hex5 = hexSeg({2'b00, status2.entered[9:8]});

	assign ledr = {win1, win2, 6'd0, status2.correct, status1.correct};

endmodule

`default_nettype wire

// File: verilog/morseBuddy.sv
/* two player Morse practice game top, keyers, generator, game FSM,
   player matchers and display */
`timescale 1ns/1ps
`default_nettype none

module morseBuddy import morsePkg::*; (
	input logic clk,
	input logic reset,
	input logic [3:0] key, // active low
	input logic [9:0] sw,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [9:0] ledr,
	output morseCodeT targetCode1,
	output morseCodeT targetCode2
);

	morseCodeT code1;
	morseCodeT code2;
	puzzleT puzzle;
	playerStatusT status1;
	playerStatusT status2;
	logic [1:0] keyEnable;
	logic [1:0] keyClear;
	logic [1:0] allDone;
	logic generateLetters;
	logic generated;
	logic play;
	logic win1;
	logic win2;

	morseKeyer u_keyer1 (
		.clk(clk), .reset(reset), .keyIn(key[0]),
		.enable(keyEnable[0]), .clear(keyClear[0]), .code(code1)
	);

	morseKeyer u_keyer2 (
		.clk(clk), .reset(reset), .keyIn(key[3]),
		.enable(keyEnable[1]), .clear(keyClear[1]), .code(code2)
	);

	letterGenerator u_letterGenerator (
		.clk(clk), .reset(reset), .seed(sw[5:0]),
		.generateLetters(generateLetters), .puzzle(puzzle), .generated(generated)
	);

	gameControl u_gameControl (
		.clk(clk), .reset(reset), .proceed({key[2], key[1]}),
		.generated(generated), .allDone(allDone),
		.generateLetters(generateLetters), .play(play), .win1(win1), .win2(win2)
	);

	playerMatch u_player1 (
		.clk(clk), .reset(reset), .proceed(key[1]), .play(play),
		.puzzle(puzzle), .entered(code1), .keyEnable(keyEnable[0]),
		.keyClear(keyClear[0]), .status(status1), .allDone(allDone[0])
	);

	playerMatch u_player2 (
		.clk(clk), .reset(reset), .proceed(key[2]), .play(play),
		.puzzle(puzzle), .entered(code2), .keyEnable(keyEnable[1]),
		.keyClear(keyClear[1]), .status(status2), .allDone(allDone[1])
	);

	statusDisplay u_statusDisplay (
		.status1(status1), .status2(status2), .win1(win1), .win2(win2),
		.hex0(hex0), .hex1(hex1), .hex2(hex2),
		.hex3(hex3), .hex4(hex4), .hex5(hex5), .ledr(ledr)
	);

	assign targetCode1 = status1.target;
	assign targetCode2 = status2.target;

endmodule

`default_nettype wire

// File: dv/morseBuddy_chk.sv
/* concurrent assertions on game outcome, bound into gameControl */
`timescale 1ns/1ps
`default_nettype none

module morseBuddyChk (
	input logic clk,
	input logic reset,
	input logic generated,
	input logic play,
	input logic win1,
	input logic win2,
	input logic [1:0] allDone
);

	winExclusive: assert property (@(posedge clk) disable iff (!reset)
		!(win1 && win2))
		else $error("win1 and win2 are both high");

	playAfterGenerate: assert property (@(posedge clk) disable iff (!reset)
		$rose(generated) |=> play) // one cycle later
		else $error("play did not follow the end of generation");

	win1NeedsDone: assert property (@(posedge clk) disable iff (!reset)
		$rose(win1) |-> $past(allDone[0]))
		else $error("player 1 win state entered without allDone");

	win2NeedsDone: assert property (@(posedge clk) disable iff (!reset)
		$rose(win2) |-> $past(allDone[1]))
		else $error("player 2 win state entered without allDone");

endmodule

bind gameControl morseBuddyChk u_morseBuddyChk (
	.clk(clk), .reset(reset), .generated(generated), .play(play),
	.win1(win1), .win2(win2), .allDone(allDone)
);

`default_nettype wire

// File: dv/morseBuddyTb.sv
/* testbench for the two player Morse game, stimulus tasks, puzzle
   reference model, compare tasks and watchdog */
`timescale 1ns/1ps
`default_nettype none

module morseBuddyTb import morsePkg::*; ();

	localparam int clkPeriod = 40;
	localparam int plannedActions = 100;
	localparam int cyclesPerAction = 200;
	localparam int shortHold = 2;
	localparam int longHold = 8;
	localparam int settleCycles = 6;
	localparam int genLimit = 400;

	logic clk;
	logic reset;
	logic [3:0] key;
	logic [9:0] sw;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	logic [9:0] ledr;
	morseCodeT targetCode1;
	morseCodeT targetCode2;

	int errorCount;
	int checkCount;
	puzzleT expPuzzle;
	int lettersDone [2];
	int slotsModel [2];
	morseCodeT entryModel [2];

	morseBuddy u_morseBuddy (
		.clk(clk), .reset(reset), .key(key), .sw(sw),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5),
		.ledr(ledr), .targetCode1(targetCode1), .targetCode2(targetCode2)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(clkPeriod * cyclesPerAction * plannedActions);
		$display("watchdog expired after %0d cycles", cyclesPerAction * plannedActions);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// LFSR walk from the seed, codes 1..36 fill the slots in order
	function automatic puzzleT modelPuzzle(input logic [5:0] seed);
		puzzleT p;
		logic [5:0] s;
		int found;
		p = '0;
		found = 0;
		s = (seed == 6'd0) ? 6'd1 : seed;
		for (int step = 0; step < 128 && found < numLetters; step++) begin
			if (s >= 6'd1 && s <= 6'(maxLetterCode)) begin
				p[found] = letterToMorse(s);
				found++;
			end
			s = {s[0] ^ s[1], s[5:1]};
		end
		return p;
	endfunction

	// gfedcba, low lights a segment
	function automatic logic [6:0] segEncode(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 7'b100_0000;
			4'h1: return 7'b111_1001;
			4'h2: return 7'b010_0100;
			4'h3: return 7'b011_0000;
			4'h4: return 7'b001_1001;
			4'h5: return 7'b001_0010;
			4'h6: return 7'b000_0010;
			4'h7: return 7'b111_1000;
			4'h8: return 7'b000_0000;
			4'h9: return 7'b001_1000;
			4'ha: return 7'b000_1000;
			4'hb: return 7'b000_0011;
			4'hc: return 7'b100_0110;
			4'hd: return 7'b010_0001;
			4'he: return 7'b000_0110;
			default: return 7'b000_1110;
		endcase
	endfunction

	function automatic morseCodeT expectTarget(input int player);
		if (lettersDone[player] >= numLetters) return '0;
		return expPuzzle[lettersDone[player]];
	endfunction

	function automatic logic expectCorrect(input int player);
		return (entryModel[player] != '0) && (entryModel[player] == expectTarget(player));
	endfunction

	function automatic morseCodeT randomWrong(input morseCodeT avoid);
		morseCodeT c;
		int len;
		logic [1:0] sym;
		c = '0;
		len = 1 + int'($urandom % symbolSlots);
		for (int s = 0; s < len; s++) begin
			sym = ($urandom % 2 == 0) ? 2'b10 : 2'b11;
			c = c | (morseCodeT'(sym) << (2 * (symbolSlots - 1 - s)));
		end
		if (c == avoid) c[8] = ~c[8]; // swap the first dot and dash
		return c;
	endfunction

	function automatic int keyIndex(input int player);
		return (player == 0) ? 0 : 3;
	endfunction

	function automatic int proceedIndex(input int player);
		return (player == 0) ? 1 : 2;
	endfunction

	task automatic checkCode(input string name, input morseCodeT expected,
		input morseCodeT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic checkSegments(input string name, input logic [6:0] expected,
		input logic [6:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic clearModels();
		for (int p = 0; p < 2; p++) begin
			lettersDone[p] = 0;
			slotsModel[p] = 0;
			entryModel[p] = '0;
		end
	endtask

	task automatic pressKey(input int index, input int held);
		@(posedge clk);
		key[index] <= 1'b0;
		repeat (held) @(posedge clk);
		key[index] <= 1'b1;
		repeat (settleCycles) @(posedge clk);
	endtask

	task automatic checkEntry(input int player, input string name);
		logic [20:0] digits;
		morseCodeT e;
		e = entryModel[player];
		@(negedge clk);
		digits = (player == 0) ? {hex2, hex1, hex0} : {hex5, hex4, hex3};
		checkSegments({name, " low digit"}, segEncode(e[3:0]), digits[6:0]);
		checkSegments({name, " mid digit"}, segEncode(e[7:4]), digits[13:7]);
		checkSegments({name, " high digit"}, segEncode({2'b00, e[9:8]}), digits[20:14]);
		checkFlag({name, " correct"}, expectCorrect(player), ledr[player]);
	endtask

	task automatic checkTarget(input int player, input string name);
		@(negedge clk);
		checkCode(name, expectTarget(player), (player == 0) ? targetCode1 : targetCode2);
	endtask

	task automatic keySymbol(input int player, input symbolT sym);
		int shift;
		pressKey(keyIndex(player), (sym == symDash) ? longHold : shortHold);
		if (slotsModel[player] < symbolSlots) begin
			shift = 2 * (symbolSlots - 1 - slotsModel[player]);
			entryModel[player] = entryModel[player] | (morseCodeT'(sym) << shift);
			slotsModel[player]++;
		end else begin
			entryModel[player] = {entryModel[player][2*symbolSlots-3:0], 2'(sym)}; // oldest drops
		end
		checkEntry(player, $sformatf("p%0d symbol", player + 1));
	endtask

	task automatic keyWord(input int player, input morseCodeT code);
		logic [1:0] slot;
		for (int s = 0; s < symbolSlots; s++) begin
			slot = 2'(code >> (2 * (symbolSlots - 1 - s)));
			if (slot == 2'b00) break;
			keySymbol(player, symbolT'(slot));
		end
	endtask

	task automatic verifyEntry(input int player);
		logic hit;
		hit = expectCorrect(player);
		pressKey(proceedIndex(player), shortHold);
		if (hit) lettersDone[player]++;
		entryModel[player] = '0;
		slotsModel[player] = 0;
		checkEntry(player, $sformatf("p%0d verify", player + 1));
		if (lettersDone[player] < numLetters) begin
			checkTarget(player, $sformatf("p%0d target after verify", player + 1));
		end
	endtask

	task automatic waitForPlay();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!u_morseBuddy.play && waited < genLimit) begin
			@(negedge clk);
			waited++;
		end
		if (!u_morseBuddy.play) begin
			errorCount++;
			$display("game never reached play after the start sequence");
		end
	endtask

	task automatic startGame(input logic [5:0] seed, input string name);
		@(posedge clk);
		sw <= {4'd0, seed};
		expPuzzle = modelPuzzle(seed);
		clearModels();
		pressKey(proceedIndex(0), shortHold);
		waitForPlay();
		checkTarget(0, {name, " p1 first target"});
		checkTarget(1, {name, " p2 first target"});
	endtask

	task automatic finishGame(input int winner, input string name);
		@(negedge clk);
		checkFlag({name, " win1"}, winner == 0, ledr[9]);
		checkFlag({name, " win2"}, winner == 1, ledr[8]);
		pressKey(proceedIndex(winner), shortHold);
		@(negedge clk);
		checkFlag({name, " win1 after finish"}, 1'b0, ledr[9]);
		checkFlag({name, " win2 after finish"}, 1'b0, ledr[8]);
		clearModels();
	endtask

	initial begin
		logic [41:0] allDigits;
		logic [5:0] seed;
		morseCodeT wrong;
		reset = 1'b0;
		key = 4'hf; // buttons released
		sw = '0;
		errorCount = 0;
		checkCount = 0;
		expPuzzle = '0;
		clearModels();
		void'($urandom(32'h4945));
		repeat (4) @(posedge clk);
		reset <= 1'b1;

		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			checkFlag($sformatf("reset ledr[%0d]", i), 1'b0, ledr[i]);
		end
		allDigits = {hex5, hex4, hex3, hex2, hex1, hex0};
		for (int i = 0; i < 6; i++) begin
			checkSegments($sformatf("reset hex%0d", i), segEncode(4'h0), allDigits[7*i +: 7]);
		end
		checkCode("reset targetCode1", '0, targetCode1);
		checkCode("reset targetCode2", '0, targetCode2);

		seed = 6'($urandom);
		startGame(seed, "game 1");

		// six symbols each, the last one shifts the code
		keySymbol(0, symDot);
		keySymbol(0, symDash);
		keySymbol(0, symDash);
		keySymbol(0, symDot);
		keySymbol(0, symDash);
		keySymbol(0, symDot);
		verifyEntry(0);
		keySymbol(1, symDash);
		keySymbol(1, symDot);
		keySymbol(1, symDot);
		keySymbol(1, symDash);
		keySymbol(1, symDash);
		keySymbol(1, symDash);
		verifyEntry(1);

		wrong = randomWrong(expectTarget(0));
		keyWord(0, wrong);
		verifyEntry(0);
		keyWord(0, expectTarget(0));
		checkFlag("p1 match before verify", 1'b1, ledr[0]);
		verifyEntry(0);

		while (lettersDone[0] < numLetters) begin
			keyWord(0, expectTarget(0));
			verifyEntry(0);
		end
		finishGame(0, "game 1");

		seed = 6'($urandom);
		startGame(seed, "game 2");
		while (lettersDone[1] < numLetters) begin
			keyWord(1, expectTarget(1));
			verifyEntry(1);
		end
		finishGame(1, "game 2");

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: morseBuddy.f
verilog/morsePkg.sv
verilog/morseKeyer.sv
verilog/letterGenerator.sv
verilog/gameControl.sv
verilog/playerMatch.sv
verilog/statusDisplay.sv
verilog/morseBuddy.sv
dv/morseBuddy_chk.sv
dv/morseBuddyTb.sv

// File: run.sh
#!/bin/sh
# build and run the morseBuddy testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f morseBuddy.f \
	--top-module morseBuddyTb -o morseBuddySim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/morseBuddySim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
